// File: design/accel_pkg.sv
package accel_pkg;

    // layer shape words
    localparam int cfg_w = 10;

    // tile geometry
    localparam int pe_count = 4;
    localparam int window_cols = pe_count + 2;

    localparam int ifmap_buf_depth = 192;
    localparam int filter_buf_depth = 128;
    localparam int ifmap_buf_aw = $clog2(ifmap_buf_depth);
    localparam int filter_buf_aw = $clog2(filter_buf_depth);

    localparam int result_count = 16;
    localparam int result_sel_w = $clog2(result_count);

    // one tile window per channel must fit the ifmap buffer
    localparam int max_ci = ifmap_buf_depth / window_cols;

endpackage

// File: design/layer_cfg_if.sv
`timescale 1ns/10ps

interface layer_cfg_if;

    logic [accel_pkg::cfg_w-1:0] h;
    logic [accel_pkg::cfg_w-1:0] w;
    logic [accel_pkg::cfg_w-1:0] ci;
    logic [accel_pkg::cfg_w-1:0] co;

    modport loader (
        output h, w, ci, co
    );

    modport user (
        input h, w, ci, co
    );

endinterface

// File: design/tile_fill_if.sv
`timescale 1ns/10ps

interface tile_fill_if;

    logic                        fill_start;
    logic                        fill_done;
    logic [accel_pkg::cfg_w-1:0] tile_row;
    logic [accel_pkg::cfg_w-1:0] tile_col;
    logic [accel_pkg::cfg_w-1:0] tile_group;

    modport seq (
        output fill_start, tile_row, tile_col, tile_group,
        input  fill_done
    );

    modport fill (
        input  fill_start, tile_row, tile_col, tile_group,
        output fill_done
    );

endinterface

// File: design/layer_config_loader.sv
`timescale 1ns/10ps

module layer_config_loader (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic [accel_pkg::cfg_w-1:0] confi,
    layer_cfg_if.loader                 cfg,
    output logic                        cfg_loaded,
    input  logic                        layer_busy
);

    logic       capturing;
    logic [1:0] word_idx;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            capturing <= 1'b0;
            word_idx <= 2'd0;
        end
        else if (!capturing)
        begin
            // a running layer masks start
            capturing <= start && !layer_busy;
            word_idx <= 2'd0;
        end
        else
        begin
            word_idx <= word_idx + 2'd1;
            if (word_idx == 2'd3)
            begin
                capturing <= 1'b0;
            end
        end
    end

    // words arrive as h, w, ci, co
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cfg.h <= '0;
            cfg.w <= '0;
            cfg.ci <= '0;
            cfg.co <= '0;
        end
        else if (capturing)
        begin
            case (word_idx)
                2'd0: cfg.h <= confi;
                2'd1: cfg.w <= confi;
                2'd2: cfg.ci <= confi;
                default: cfg.co <= confi;
            endcase
        end
    end

    assign cfg_loaded = capturing && (word_idx == 2'd3);

endmodule

// File: design/tile_sequencer.sv
`timescale 1ns/10ps

module tile_sequencer (
    input  logic     clk,
    input  logic     rst,
    layer_cfg_if.user cfg,
    input  logic     cfg_loaded,
    tile_fill_if.seq fill,
    output logic     compute_start,
    input  logic     compute_done,
    output logic     drain_start,
    input  logic     drain_done,
    output logic     layer_busy
);

    localparam int ext_w = accel_pkg::cfg_w + 1;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_fill = 2'd1;
    localparam logic [1:0] st_compute = 2'd2;
    localparam logic [1:0] st_drain = 2'd3;

    logic [1:0] state;
    logic       col_last;
    logic       row_last;
    logic       group_last;
    logic       last_tile;

    // next window would run past the right edge
    assign col_last = ext_w'(fill.tile_col) + ext_w'(accel_pkg::pe_count + accel_pkg::window_cols)
                      > ext_w'(cfg.w);
    assign row_last = fill.tile_row == cfg.h - 1'b1;
    assign group_last = fill.tile_group + 1'b1 == (cfg.co >> $clog2(accel_pkg::pe_count));
    assign last_tile = col_last && row_last && group_last;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= st_idle;
            fill.tile_row <= '0;
            fill.tile_col <= '0;
            fill.tile_group <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (cfg_loaded)
                    begin
                        state <= st_fill;
                    end
                end
                st_fill:
                begin
                    if (fill.fill_done)
                    begin
                        state <= st_compute;
                    end
                end
                st_compute:
                begin
                    if (compute_done)
                    begin
                        state <= st_drain;
                    end
                end
                default:
                begin
                    if (drain_done)
                    begin
                        state <= last_tile ? st_idle : st_fill;
                        // col innermost, then row, then filter group
                        if (!col_last)
                        begin
                            fill.tile_col <= fill.tile_col + accel_pkg::cfg_w'(accel_pkg::pe_count);
                        end
                        else
                        begin
                            fill.tile_col <= '0;
                            if (!row_last)
                            begin
                                fill.tile_row <= fill.tile_row + 1'b1;
                            end
                            else
                            begin
                                fill.tile_row <= '0;
                                fill.tile_group <= last_tile ? '0 : fill.tile_group + 1'b1;
                            end
                        end
                    end
                end
            endcase
        end
    end

    // phases chain back to back
    assign fill.fill_start = (state == st_idle && cfg_loaded)
                             || (state == st_drain && drain_done && !last_tile);
    assign compute_start = (state == st_fill) && fill.fill_done;
    assign drain_start = (state == st_compute) && compute_done;
    assign layer_busy = state != st_idle;

endmodule

// File: design/buffer_fill.sv
`timescale 1ns/10ps

module buffer_fill #(
    parameter int SRAM_ADDR_W = 17
) (
    input  logic                                  clk,
    input  logic                                  rst,
    layer_cfg_if.user                             cfg,
    tile_fill_if.fill                             fill,
    output logic [SRAM_ADDR_W-1:0]                ifmap_sram_addr,
    output logic [SRAM_ADDR_W-1:0]                filter_sram_addr,
    output logic                                  ifmap_sram_ren,
    output logic                                  filter_sram_ren,
    output logic [accel_pkg::ifmap_buf_aw-1:0]    ifmap_buffer_waddr,
    output logic                                  ifmap_buffer_wen,
    output logic [accel_pkg::filter_buf_aw-1:0]   filter_buffer_waddr,
    output logic                                  filter_buffer_wen
);

    localparam int ch_w = $clog2(accel_pkg::max_ci) + 1;
    localparam int ik_w = $clog2(accel_pkg::window_cols);
    localparam int fk_w = $clog2(accel_pkg::pe_count);

    logic [ik_w-1:0]        i_k;
    logic [ch_w-1:0]        i_ch;
    logic [fk_w-1:0]        f_k;
    logic [ch_w-1:0]        f_ch;
    logic [ch_w-1:0]        last_ch;
    logic [SRAM_ADDR_W-1:0] chan_off;
    logic [SRAM_ADDR_W-1:0] plane_size;

    assign last_ch = ch_w'(cfg.ci - 1'b1);
    assign plane_size = SRAM_ADDR_W'(cfg.h) * SRAM_ADDR_W'(cfg.w);

    // ifmap side, channel outer and window column inner
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ifmap_sram_ren <= 1'b0;
            i_k <= '0;
            i_ch <= '0;
            chan_off <= '0;
        end
        else if (fill.fill_start)
        begin
            ifmap_sram_ren <= 1'b1;
            i_k <= '0;
            i_ch <= '0;
            chan_off <= '0;
        end
        else if (ifmap_sram_ren)
        begin
            if (i_k == ik_w'(accel_pkg::window_cols - 1))
            begin
                i_k <= '0;
                i_ch <= i_ch + 1'b1;
                chan_off <= chan_off + plane_size;
                if (i_ch == last_ch)
                begin
                    ifmap_sram_ren <= 1'b0;
                end
            end
            else
            begin
                i_k <= i_k + 1'b1;
            end
        end
    end

    // filter side, four filters per channel
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            filter_sram_ren <= 1'b0;
            f_k <= '0;
            f_ch <= '0;
        end
        else if (fill.fill_start)
        begin
            filter_sram_ren <= 1'b1;
            f_k <= '0;
            f_ch <= '0;
        end
        else if (filter_sram_ren)
        begin
            f_k <= f_k + 1'b1;
            if (f_k == fk_w'(accel_pkg::pe_count - 1))
            begin
                f_ch <= f_ch + 1'b1;
                if (f_ch == last_ch)
                begin
                    filter_sram_ren <= 1'b0;
                end
            end
        end
    end

    assign ifmap_sram_addr = SRAM_ADDR_W'(cfg.w) * SRAM_ADDR_W'(fill.tile_row)
                             + SRAM_ADDR_W'(fill.tile_col) + chan_off + SRAM_ADDR_W'(i_k);
    assign filter_sram_addr = (SRAM_ADDR_W'(fill.tile_group) * SRAM_ADDR_W'(accel_pkg::pe_count)
                               + SRAM_ADDR_W'(f_k)) * SRAM_ADDR_W'(cfg.ci) + SRAM_ADDR_W'(f_ch);

    // sram data lands one cycle after the read
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ifmap_buffer_wen <= 1'b0;
            filter_buffer_wen <= 1'b0;
            ifmap_buffer_waddr <= '0;
            filter_buffer_waddr <= '0;
        end
        else
        begin
            ifmap_buffer_wen <= ifmap_sram_ren;
            filter_buffer_wen <= filter_sram_ren;
            if (fill.fill_start)
            begin
                ifmap_buffer_waddr <= '0;
                filter_buffer_waddr <= '0;
            end
            else
            begin
                ifmap_buffer_waddr <= ifmap_buffer_waddr + ifmap_buffer_wen;
                filter_buffer_waddr <= filter_buffer_waddr + filter_buffer_wen;
            end
        end
    end

    // ifmap stream is the longer one
    assign fill.fill_done = ifmap_buffer_wen && !ifmap_sram_ren;

endmodule

// File: design/pe_dispatch.sv
`timescale 1ns/10ps

module pe_dispatch (
    input  logic     clk,
    input  logic     rst,
    layer_cfg_if.user cfg,
    input  logic     compute_start,
    output logic     compute_done,
    output logic [accel_pkg::pe_count-1:0][accel_pkg::ifmap_buf_aw-1:0]  ifmap_raddr,
    output logic [accel_pkg::pe_count-1:0]                               ifmap_ren,
    output logic [accel_pkg::pe_count-1:0][accel_pkg::filter_buf_aw-1:0] filter_raddr,
    output logic [accel_pkg::pe_count-1:0]                               filter_ren
);

    localparam int ch_w = $clog2(accel_pkg::max_ci) + 1;
    localparam int stg_w = $clog2(accel_pkg::pe_count);

    logic             running;
    logic [stg_w-1:0] stagger;
    logic [ch_w-1:0]  ch [accel_pkg::pe_count];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            running <= 1'b0;
            stagger <= '0;
        end
        else if (compute_start)
        begin
            running <= 1'b1;
            stagger <= '0;
        end
        else if (running)
        begin
            // saturates once the last PE is enabled
            if (stagger != stg_w'(accel_pkg::pe_count - 1))
            begin
                stagger <= stagger + 1'b1;
            end
            if (compute_done)
            begin
                running <= 1'b0;
            end
        end
    end

    always_comb
    begin
        for (int p = 0; p < accel_pkg::pe_count; p++)
        begin
            ifmap_ren[p] = running && (stagger >= stg_w'(p)) && (ch[p] != cfg.ci[ch_w-1:0]);
        end
    end

    assign filter_ren = ifmap_ren;
    assign compute_done = ifmap_ren[accel_pkg::pe_count-1]
                          && (ch[accel_pkg::pe_count-1] == ch_w'(cfg.ci - 1'b1));

    // per PE channel count and buffer addresses
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int p = 0; p < accel_pkg::pe_count; p++)
            begin
                ch[p] <= '0;
                ifmap_raddr[p] <= '0;
                filter_raddr[p] <= '0;
            end
        end
        else
        begin
            for (int p = 0; p < accel_pkg::pe_count; p++)
            begin
                if (compute_start)
                begin
                    ch[p] <= '0;
                    ifmap_raddr[p] <= accel_pkg::ifmap_buf_aw'(p);
                    filter_raddr[p] <= accel_pkg::filter_buf_aw'(p);
                end
                else if (ifmap_ren[p])
                begin
                    ch[p] <= ch[p] + 1'b1;
                    ifmap_raddr[p] <= ifmap_raddr[p]
                                      + accel_pkg::ifmap_buf_aw'(accel_pkg::window_cols);
                    filter_raddr[p] <= filter_raddr[p]
                                       + accel_pkg::filter_buf_aw'(accel_pkg::pe_count);
                end
            end
        end
    end

endmodule

// File: design/result_drain.sv
`timescale 1ns/10ps

module result_drain (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               drain_start,
    output logic                               drain_done,
    output logic [accel_pkg::result_sel_w-1:0] result_sel,
    output logic                               post_unit_wen
);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            post_unit_wen <= 1'b0;
            result_sel <= '0;
        end
        else if (drain_start)
        begin
            post_unit_wen <= 1'b1;
            result_sel <= '0;
        end
        else if (post_unit_wen)
        begin
            // wraps back to zero after the last select
            result_sel <= result_sel + 1'b1;
            if (drain_done)
            begin
                post_unit_wen <= 1'b0;
            end
        end
    end

    assign drain_done = post_unit_wen
                        && (result_sel == accel_pkg::result_sel_w'(accel_pkg::result_count - 1));

endmodule

// File: design/accel_controller.sv
`timescale 1ns/10ps

module accel_controller #(
    parameter int SRAM_ADDR_W = 17
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start,
    input  logic [accel_pkg::cfg_w-1:0]           confi,
    output logic [SRAM_ADDR_W-1:0]                ifmap_sram_addr,
    output logic [SRAM_ADDR_W-1:0]                filter_sram_addr,
    output logic                                  ifmap_sram_ren,
    output logic                                  filter_sram_ren,
    output logic [accel_pkg::ifmap_buf_aw-1:0]    ifmap_buffer_waddr,
    output logic                                  ifmap_buffer_wen,
    output logic [accel_pkg::filter_buf_aw-1:0]   filter_buffer_waddr,
    output logic                                  filter_buffer_wen,
    output logic [accel_pkg::pe_count-1:0][accel_pkg::ifmap_buf_aw-1:0]  ifmap_raddr,
    output logic [accel_pkg::pe_count-1:0]                               ifmap_ren,
    output logic [accel_pkg::pe_count-1:0][accel_pkg::filter_buf_aw-1:0] filter_raddr,
    output logic [accel_pkg::pe_count-1:0]                               filter_ren,
    output logic [accel_pkg::result_sel_w-1:0]    result_sel,
    output logic                                  post_unit_wen
);

    logic cfg_loaded;
    logic layer_busy;
    logic compute_start;
    logic compute_done;
    logic drain_start;
    logic drain_done;

    layer_cfg_if cfg_bus ();
    tile_fill_if fill_bus ();

    layer_config_loader u_loader (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .confi      (confi),
        .cfg        (cfg_bus.loader),
        .cfg_loaded (cfg_loaded),
        .layer_busy (layer_busy)
    );

    tile_sequencer u_sequencer (
        .clk           (clk),
        .rst           (rst),
        .cfg           (cfg_bus.user),
        .cfg_loaded    (cfg_loaded),
        .fill          (fill_bus.seq),
        .compute_start (compute_start),
        .compute_done  (compute_done),
        .drain_start   (drain_start),
        .drain_done    (drain_done),
        .layer_busy    (layer_busy)
    );

    buffer_fill #(
        .SRAM_ADDR_W (SRAM_ADDR_W)
    ) u_fill (
        .clk                 (clk),
        .rst                 (rst),
        .cfg                 (cfg_bus.user),
        .fill                (fill_bus.fill),
        .ifmap_sram_addr     (ifmap_sram_addr),
        .filter_sram_addr    (filter_sram_addr),
        .ifmap_sram_ren      (ifmap_sram_ren),
        .filter_sram_ren     (filter_sram_ren),
        .ifmap_buffer_waddr  (ifmap_buffer_waddr),
        .ifmap_buffer_wen    (ifmap_buffer_wen),
        .filter_buffer_waddr (filter_buffer_waddr),
        .filter_buffer_wen   (filter_buffer_wen)
    );

    pe_dispatch u_dispatch (
        .clk           (clk),
        .rst           (rst),
        .cfg           (cfg_bus.user),
        .compute_start (compute_start),
        .compute_done  (compute_done),
        .ifmap_raddr   (ifmap_raddr),
        .ifmap_ren     (ifmap_ren),
        .filter_raddr  (filter_raddr),
        .filter_ren    (filter_ren)
    );

    result_drain u_drain (
        .clk           (clk),
        .rst           (rst),
        .drain_start   (drain_start),
        .drain_done    (drain_done),
        .result_sel    (result_sel),
        .post_unit_wen (post_unit_wen)
    );

endmodule

// File: dv/accel_controller_tb.sv
`timescale 1ns/10ps

module accel_controller_tb;

    localparam int sram_aw = 17;

    logic                        clk;
    logic                        rst;
    logic                        start;
    logic [accel_pkg::cfg_w-1:0] confi;

    logic [sram_aw-1:0]                    ifmap_sram_addr;
    logic [sram_aw-1:0]                    filter_sram_addr;
    logic                                  ifmap_sram_ren;
    logic                                  filter_sram_ren;
    logic [accel_pkg::ifmap_buf_aw-1:0]    ifmap_buffer_waddr;
    logic                                  ifmap_buffer_wen;
    logic [accel_pkg::filter_buf_aw-1:0]   filter_buffer_waddr;
    logic                                  filter_buffer_wen;
    logic [3:0][accel_pkg::ifmap_buf_aw-1:0]  ifmap_raddr;
    logic [3:0]                               ifmap_ren;
    logic [3:0][accel_pkg::filter_buf_aw-1:0] filter_raddr;
    logic [3:0]                               filter_ren;
    logic [accel_pkg::result_sel_w-1:0]    result_sel;
    logic                                  post_unit_wen;

    // reference model state
    logic [15:0] lfsr_state;
    int          cycle_no;
    int          start_at;
    logic        layer_on;
    int          m_h;
    int          m_w;
    int          m_ci;
    int          m_co;
    int          m_ncols;
    int          m_tiles;
    int          m_len;
    int          drains;
    int          watch_cycles;

    accel_controller #(
        .SRAM_ADDR_W (sram_aw)
    ) UUT (
        .clk                 (clk),
        .rst                 (rst),
        .start               (start),
        .confi               (confi),
        .ifmap_sram_addr     (ifmap_sram_addr),
        .filter_sram_addr    (filter_sram_addr),
        .ifmap_sram_ren      (ifmap_sram_ren),
        .filter_sram_ren     (filter_sram_ren),
        .ifmap_buffer_waddr  (ifmap_buffer_waddr),
        .ifmap_buffer_wen    (ifmap_buffer_wen),
        .filter_buffer_waddr (filter_buffer_waddr),
        .filter_buffer_wen   (filter_buffer_wen),
        .ifmap_raddr         (ifmap_raddr),
        .ifmap_ren           (ifmap_ren),
        .filter_raddr        (filter_raddr),
        .filter_ren          (filter_ren),
        .result_sel          (result_sel),
        .post_unit_wen       (post_unit_wen)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "stopped on the first failed check");
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk)
    begin
        int rel;
        int u;
        int ti;
        int row;
        int grp;
        int t;
        logic exp_iren;
        logic exp_fren;
        logic exp_iwen;
        logic exp_fwen;
        logic exp_post;
        int exp_iaddr;
        int exp_faddr;
        logic [3:0] exp_pren;
        int exp_ira [4];
        int exp_fra [4];

        cycle_no++;
        rel = cycle_no - start_at;
        exp_iren = 1'b0;
        exp_fren = 1'b0;
        exp_iwen = 1'b0;
        exp_fwen = 1'b0;
        exp_post = 1'b0;
        exp_pren = '0;
        exp_iaddr = 0;
        exp_faddr = 0;
        u = 0;
        if (layer_on && rel >= 5 && rel < 5 + m_tiles * m_len)
        begin
            u = (rel - 5) % m_len;
            ti = (rel - 5) / m_len;
            row = (ti / m_ncols) % m_h;
            grp = ti / (m_ncols * m_h);
            exp_iren = u < 6 * m_ci;
            exp_fren = u < 4 * m_ci;
            exp_iaddr = m_w * row + 4 * (ti % m_ncols) + m_h * m_w * (u / 6) + u % 6;
            exp_faddr = (4 * grp + u % 4) * m_ci + u / 4;
            exp_iwen = u >= 1 && u <= 6 * m_ci;
            exp_fwen = u >= 1 && u <= 4 * m_ci;
            t = u - (6 * m_ci + 1);
            for (int p = 0; p < 4; p++)
            begin
                exp_pren[p] = t >= p && t <= p + m_ci - 1;
                exp_ira[p] = 6 * (t - p) + p;
                exp_fra[p] = 4 * (t - p) + p;
            end
            exp_post = u >= 7 * m_ci + 4;
        end

        if (!rst)
        begin
            assert (ifmap_sram_ren == exp_iren && filter_sram_ren == exp_fren)
            else report_error($sformatf("sram ren %b%b, expected %b%b at layer cycle %0d",
                ifmap_sram_ren, filter_sram_ren, exp_iren, exp_fren, rel));
            assert (!exp_iren || int'(ifmap_sram_addr) == exp_iaddr)
            else report_error($sformatf("ifmap_sram_addr %0d, expected %0d",
                ifmap_sram_addr, exp_iaddr));
            assert (!exp_fren || int'(filter_sram_addr) == exp_faddr)
            else report_error($sformatf("filter_sram_addr %0d, expected %0d",
                filter_sram_addr, exp_faddr));
            assert (ifmap_buffer_wen == exp_iwen && filter_buffer_wen == exp_fwen)
            else report_error("buffer wen out of its write window");
            assert (!exp_iwen || int'(ifmap_buffer_waddr) == u - 1)
            else report_error($sformatf("ifmap_buffer_waddr %0d, expected %0d",
                ifmap_buffer_waddr, u - 1));
            assert (!exp_fwen || int'(filter_buffer_waddr) == u - 1)
            else report_error($sformatf("filter_buffer_waddr %0d, expected %0d",
                filter_buffer_waddr, u - 1));
            assert (ifmap_ren == exp_pren && filter_ren == exp_pren)
            else report_error($sformatf("pe ren %b/%b, expected %b",
                ifmap_ren, filter_ren, exp_pren));
            for (int p = 0; p < 4; p++)
            begin
                assert (!exp_pren[p] || (int'(ifmap_raddr[p]) == exp_ira[p]
                        && int'(filter_raddr[p]) == exp_fra[p]))
                else report_error($sformatf("pe %0d raddr %0d/%0d, expected %0d/%0d", p,
                    ifmap_raddr[p], filter_raddr[p], exp_ira[p], exp_fra[p]));
            end
            assert (post_unit_wen == exp_post)
            else report_error($sformatf("post_unit_wen %b, expected %b", post_unit_wen,
                exp_post));
            assert (!exp_post || int'(result_sel) == u - (7 * m_ci + 4))
            else report_error($sformatf("result_sel %0d, expected %0d", result_sel,
                u - (7 * m_ci + 4)));
            // no layer has run since reset
            assert (layer_on || (ifmap_sram_addr == '0 && filter_sram_addr == '0
                    && ifmap_raddr == '0 && filter_raddr == '0 && result_sel == '0))
            else report_error("address or result_sel not zero after reset");
            if (post_unit_wen && result_sel == 4'd15)
            begin
                drains++;
            end
        end
    end

    task automatic run_layer(input int h, input int w, input int ci, input int co);
        @(posedge clk);
        #1;
        m_h = h;
        m_w = w;
        m_ci = ci;
        m_co = co;
        m_ncols = (w - 6) / 4 + 1;
        m_tiles = (co / 4) * h * m_ncols;
        m_len = 7 * ci + 20;
        drains = 0;
        start_at = cycle_no + 1;
        layer_on = 1'b1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        confi = accel_pkg::cfg_w'(h);
        @(posedge clk);
        #1;
        confi = accel_pkg::cfg_w'(w);
        @(posedge clk);
        #1;
        confi = accel_pkg::cfg_w'(ci);
        @(posedge clk);
        #1;
        confi = accel_pkg::cfg_w'(co);
        @(posedge clk);
        #1;
        confi = '0;
        // stray start in the middle of the layer
        repeat (6) @(posedge clk);
        #1;
        start = 1'b1;
        confi = '1;
        @(posedge clk);
        #1;
        start = 1'b0;
        confi = '0;
        // layer length is fixed by its shape, then a quiet stretch
        wait (cycle_no >= start_at + 5 + m_tiles * m_len + 20);
        assert (drains == m_tiles)
        else report_error($sformatf("%0d drains, expected %0d", drains, m_tiles));
    endtask

    initial
    begin
        wait (watch_cycles != 0);
        #(watch_cycles * 10);
        $display("watchdog expired, run did not finish within %0d cycles", watch_cycles);
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    initial
    begin
        int sh [2];
        int sw [2];
        int sc [2];
        int so [2];
        int v;
        int budget;

        rst = 1'b1;
        start = 1'b0;
        confi = '0;
        cycle_no = 0;
        start_at = 0;
        layer_on = 1'b0;
        drains = 0;
        m_h = 1;
        m_w = 6;
        m_ci = 1;
        m_co = 4;
        m_ncols = 1;
        m_tiles = 0;
        m_len = 27;
        watch_cycles = 0;
        lfsr_state = 16'd54;
        budget = 0;
        for (int i = 0; i < 2; i++)
        begin
            draw_bits(2, v);
            sh[i] = v % 3 + 1;
            draw_bits(3, v);
            sw[i] = v % 6 + 6;
            draw_bits(3, v);
            sc[i] = v + 1;
            draw_bits(1, v);
            so[i] = 4 * (v + 1);
            budget += (so[i] / 4) * sh[i] * ((sw[i] - 6) / 4 + 1) * (7 * sc[i] + 20) + 40;
        end
        watch_cycles = budget + 10 + 100;

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (5) @(posedge clk);
        for (int i = 0; i < 2; i++)
        begin
            $display("layer %0d: h %0d w %0d ci %0d co %0d", i, sh[i], sw[i], sc[i], so[i]);
            run_layer(sh[i], sw[i], sc[i], so[i]);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// File: accel_controller.f
design/accel_pkg.sv
design/layer_cfg_if.sv
design/tile_fill_if.sv
design/layer_config_loader.sv
design/tile_sequencer.sv
design/buffer_fill.sv
design/pe_dispatch.sv
design/result_drain.sv
design/accel_controller.sv
dv/accel_controller_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
        --top-module accel_controller_tb -f accel_controller.f -o accel_controller_sim \
    && ./obj_dir/accel_controller_sim \
    || exit 1
